// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 64;
    localparam int ways = 2;
    localparam int sets = 2;
    localparam int line_bytes = 64;
    localparam int beats_per_line = line_bytes / (data_width / 8); // 8 doublewords per line
    localparam int offset_width = $clog2(line_bytes);
    localparam int word_sel_width = $clog2(beats_per_line);
    localparam int set_width = $clog2(sets);
    localparam int tag_width = addr_width - offset_width - set_width;

    // AXI burst fields for a full line
    localparam logic [7:0] axi_len_line = 8'd7;
    localparam logic [2:0] axi_size_dword = 3'd3;
    localparam logic [1:0] axi_burst_incr = 2'd1;
    localparam logic [7:0] strb_all = 8'hff;

    typedef enum logic [2:0] {
        size_byte  = 3'd1,
        size_half  = 3'd2,
        size_word  = 3'd4,
        size_dword = 3'd7
    } access_size_e;

    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_evict_addr,
        st_evict_data,
        st_evict_resp,
        st_fill_addr,
        st_fill_data,
        st_install,
        st_respond
    } cache_state_e;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] addr;
        access_size_e          size;
        logic [data_width-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                  done;
        logic [data_width-1:0] rdata;
    } cpu_resp_t;

    // Shared by AR and AW
    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_addr_t;

    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] data;
        logic                  last;
    } axi_r_t;

    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] data;
        logic [7:0]            strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic                 hit;
        logic                 hit_way;
        logic                 victim_way;
        logic                 victim_dirty;
        logic [tag_width-1:0] victim_tag;
    } lookup_t;

endpackage

// ==== src/beat_counter.sv ====
`timescale 1ns/10ps

module beat_counter (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                clear,
    input  logic                                advance,
    output logic [dcache_pkg::word_sel_width-1:0] beat,
    output logic                                last_beat
);
    import dcache_pkg::*;

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            beat <= '0;
        end else if (advance) begin
            beat <= beat + 1'b1; // Wraps to zero after the eighth beat
        end
    end

    assign last_beat = (beat == word_sel_width'(beats_per_line - 1));

    // Eighth beat ends the burst, the next burst starts from a clear
    assert property (@(posedge clock) disable iff (reset)
        (advance && last_beat && !clear) |=> !advance);

endmodule

// ==== src/tag_store.sv ====
`timescale 1ns/10ps

module tag_store (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [dcache_pkg::addr_width-1:0] addr,
    input  logic                            install_en,
    input  logic                            mark_dirty,
    input  logic                            evict_rotate,
    input  logic                            fill_way,
    output dcache_pkg::lookup_t             look
);
    import dcache_pkg::*;

    logic [tag_width-1:0] tags [sets][ways];
    logic [ways-1:0]      valid_q [sets];
    logic [ways-1:0]      dirty_q [sets];
    logic                 rr_ptr;   // Round-robin victim pointer
    logic [set_width-1:0] set_idx;
    logic [tag_width-1:0] tag;
    logic [ways-1:0]      way_hit;

    assign set_idx = addr[offset_width +: set_width];
    assign tag     = addr[addr_width-1 -: tag_width];

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            way_hit[w] = valid_q[set_idx][w] && (tags[set_idx][w] == tag);
        end
        look.hit     = |way_hit;
        look.hit_way = way_hit[1];
        // First invalid way wins, otherwise the pointer
        if (!valid_q[set_idx][0])      look.victim_way = 1'b0;
        else if (!valid_q[set_idx][1]) look.victim_way = 1'b1;
        else                           look.victim_way = rr_ptr;
        look.victim_dirty = valid_q[set_idx][look.victim_way] && dirty_q[set_idx][look.victim_way];
        look.victim_tag   = tags[set_idx][look.victim_way];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            rr_ptr <= 1'b0;
        end else begin
            if (install_en) begin
                valid_q[set_idx][fill_way] <= 1'b1;
                dirty_q[set_idx][fill_way] <= 1'b0; // Fresh line is clean
            end
            if (mark_dirty && look.hit)
                dirty_q[set_idx][look.hit_way] <= 1'b1;
            if (evict_rotate)
                rr_ptr <= ~rr_ptr;
        end
    end

    always_ff @(posedge clock) begin
        if (install_en) tags[set_idx][fill_way] <= tag;
    end

    // A line is never installed twice in one set
    assert property (@(posedge clock) disable iff (reset) $onehot0(way_hit));

endmodule

// ==== src/line_store.sv ====
`timescale 1ns/10ps

module line_store (
    input  logic                                  clock,
    input  logic                                  set_sel,
    input  logic                                  way_sel,
    input  logic [dcache_pkg::word_sel_width-1:0] word_sel,
    input  logic [dcache_pkg::word_sel_width-1:0] beat,
    input  logic                                  fill_en,
    input  logic                                  cpu_write_en,
    input  logic [dcache_pkg::data_width-1:0]     fill_data,
    input  dcache_pkg::access_size_e              size,
    input  logic [dcache_pkg::data_width-1:0]     wdata,
    output logic [dcache_pkg::data_width-1:0]     rdata,
    output logic [dcache_pkg::data_width-1:0]     wb_data
);
    import dcache_pkg::*;

    logic [data_width-1:0] lines [sets][ways][beats_per_line];
    logic [data_width-1:0] word;
    logic [data_width-1:0] size_mask;

    assign word = lines[set_sel][way_sel][word_sel];

    always_comb begin
        case (size)
            size_byte: size_mask = 64'h0000_0000_0000_00ff;
            size_half: size_mask = 64'h0000_0000_0000_ffff;
            size_word: size_mask = 64'h0000_0000_ffff_ffff;
            default:   size_mask = '1;
        endcase
    end

    assign rdata   = word & size_mask;               // Zero-extended low bytes
    assign wb_data = lines[set_sel][way_sel][beat];   // Beat for the W channel

    always_ff @(posedge clock) begin
        if (fill_en) begin
            lines[set_sel][way_sel][beat] <= fill_data;
        end else if (cpu_write_en) begin
            // Keep the upper bytes, replace the low size bytes
            lines[set_sel][way_sel][word_sel] <= (word & ~size_mask) | (wdata & size_mask);
        end
    end

    assert property (@(posedge clock) !(fill_en && cpu_write_en));

endmodule

// ==== src/dcache_fsm.sv ====
`timescale 1ns/10ps

module dcache_fsm (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::cpu_req_t  req,
    input  dcache_pkg::lookup_t   look,
    input  logic                  last_beat,
    input  logic                  ar_ready,
    input  logic                  aw_ready,
    input  logic                  w_ready,
    input  dcache_pkg::axi_r_t    r_in,
    input  dcache_pkg::axi_b_t    b_in,
    output dcache_pkg::axi_addr_t ar_out,
    output dcache_pkg::axi_addr_t aw_out,
    output logic                  w_valid,
    output logic                  w_last,
    output logic                  r_ready,
    output logic                  b_ready,
    output logic                  lookup_en,
    output logic                  cpu_write_en,
    output logic                  fill_en,
    output logic                  install_en,
    output logic                  mark_dirty,
    output logic                  evict_rotate,
    output logic                  beat_clear,
    output logic                  beat_advance,
    output logic                  done
);
    import dcache_pkg::*;

    cache_state_e state, next_state;
    cpu_req_t     req_q;

    always_ff @(posedge clock) begin
        if (reset) state <= st_idle;
        else       state <= next_state;
    end

    always_ff @(posedge clock) begin
        if (lookup_en) req_q <= req;
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:       if (req.read || req.write) next_state = st_lookup;
            st_lookup: begin
                if (look.hit)               next_state = st_respond;
                else if (look.victim_dirty) next_state = st_evict_addr;
                else                        next_state = st_fill_addr;
            end
            st_evict_addr: if (aw_ready) next_state = st_evict_data;
            st_evict_data: if (w_ready && last_beat) next_state = st_evict_resp;
            st_evict_resp: if (b_in.valid) next_state = st_fill_addr; // Response code ignored
            st_fill_addr:  if (ar_ready) next_state = st_fill_data;
            st_fill_data:  if (r_in.valid && last_beat) next_state = st_install;
            st_install:    next_state = st_respond;
            st_respond:    next_state = st_idle;
            default:       next_state = st_idle;
        endcase
    end

    // Line-aligned refill address
    assign ar_out.valid = (state == st_fill_addr);
    assign ar_out.addr  = {req_q.addr[addr_width-1:offset_width], {offset_width{1'b0}}};
    assign ar_out.len   = axi_len_line;
    assign ar_out.size  = axi_size_dword;
    assign ar_out.burst = axi_burst_incr;

    // Victim line address rebuilt from its tag and the set
    assign aw_out.valid = (state == st_evict_addr);
    assign aw_out.addr  = {look.victim_tag, req_q.addr[offset_width +: set_width],
                           {offset_width{1'b0}}};
    assign aw_out.len   = axi_len_line;
    assign aw_out.size  = axi_size_dword;
    assign aw_out.burst = axi_burst_incr;

    assign w_valid = (state == st_evict_data);
    assign w_last  = w_valid && last_beat;
    assign r_ready = (state == st_fill_data);
    assign b_ready = (state == st_evict_resp);

    assign lookup_en    = (state == st_idle) && (req.read || req.write);
    assign cpu_write_en = req_q.write &&
                          (((state == st_lookup) && look.hit) || (state == st_install));
    assign fill_en      = r_ready && r_in.valid;
    assign install_en   = (state == st_install);
    assign evict_rotate = (state == st_install);
    assign mark_dirty   = (state == st_respond) && req_q.write; // Line hits by now
    assign beat_clear   = (state == st_evict_addr) || (state == st_fill_addr);
    assign beat_advance = (w_valid && w_ready) || fill_en;
    assign done         = (state == st_respond);

    assert property (@(posedge clock) disable iff (reset) done |=> !done);

    assert property (@(posedge clock) disable iff (reset)
        (ar_out.valid && !ar_ready) |=> (ar_out.valid && $stable(ar_out.addr)));

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::cpu_req_t  req,
    output dcache_pkg::cpu_resp_t resp,
    output dcache_pkg::axi_addr_t ar,
    input  logic                  ar_ready,
    input  dcache_pkg::axi_r_t    r_in,
    output logic                  r_ready,
    output dcache_pkg::axi_addr_t aw,
    input  logic                  aw_ready,
    output dcache_pkg::axi_w_t    w_out,
    input  logic                  w_ready,
    input  dcache_pkg::axi_b_t    b_in,
    output logic                  b_ready
);
    import dcache_pkg::*;

    lookup_t                   look;
    logic                      last_beat;
    logic [word_sel_width-1:0] beat;
    logic                      w_valid;
    logic                      w_last;
    logic                      cpu_write_en;
    logic                      fill_en;
    logic                      install_en;
    logic                      mark_dirty;
    logic                      evict_rotate;
    logic                      beat_clear;
    logic                      beat_advance;
    logic                      way_sel;
    logic [data_width-1:0]     wb_data;

    assign way_sel = look.hit ? look.hit_way : look.victim_way; // Victim during refill
    assign w_out   = '{valid: w_valid, data: wb_data, strb: strb_all, last: w_last};

    dcache_fsm i_fsm (
        .clock, .reset, .req, .look, .last_beat,
        .ar_ready, .aw_ready, .w_ready, .r_in, .b_in,
        .ar_out(ar), .aw_out(aw), .w_valid, .w_last, .r_ready, .b_ready,
        .lookup_en(), .cpu_write_en, .fill_en, .install_en, .mark_dirty,
        .evict_rotate, .beat_clear, .beat_advance, .done(resp.done)
    );

    beat_counter i_beats (
        .clock, .reset, .clear(beat_clear), .advance(beat_advance), .beat, .last_beat
    );

    tag_store i_tags (
        .clock, .reset, .addr(req.addr), .install_en, .mark_dirty, .evict_rotate,
        .fill_way(look.victim_way), .look
    );

    line_store i_lines (
        .clock,
        .set_sel(req.addr[offset_width]),
        .way_sel,
        .word_sel(req.addr[offset_width-1 -: word_sel_width]),
        .beat, .fill_en, .cpu_write_en,
        .fill_data(r_in.data),
        .size(req.size),
        .wdata(req.wdata),
        .rdata(resp.rdata),
        .wb_data
    );

endmodule

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/10ps

module axi_mem_model (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::axi_addr_t ar,
    output logic                  ar_ready,
    output dcache_pkg::axi_r_t    r_in,
    input  dcache_pkg::axi_addr_t aw,
    output logic                  aw_ready,
    input  dcache_pkg::axi_w_t    w_out,
    output logic                  w_ready,
    output dcache_pkg::axi_b_t    b_in
);
    import dcache_pkg::*;

    localparam logic [31:0] base_addr   = 32'h0004_0000;
    localparam logic [63:0] pattern_key = 64'h5a3c_96e1_0f87_d2b4;

    logic [data_width-1:0] mem [64]; // 512 bytes from base_addr up

    // Zero to three idle cycles, always ends just after a rising edge
    task automatic idle_cycles();
        repeat ($urandom % 4) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic serve_read(input logic [addr_width-1:0] addr);
        @(posedge clock);
        #1;
        idle_cycles();
        ar_ready = 1'b1;
        @(posedge clock);
        #1;
        ar_ready = 1'b0;
        for (int i = 0; i < beats_per_line; i++) begin
            idle_cycles();
            r_in = '{valid: 1'b1, data: mem[{addr[8:6], 3'(i)}], last: (i == beats_per_line - 1)};
            @(posedge clock); // r_ready is high for the whole burst
            #1;
            r_in = '0;
        end
    endtask

    task automatic serve_write(input logic [addr_width-1:0] addr);
        @(posedge clock);
        #1;
        idle_cycles();
        aw_ready = 1'b1;
        @(posedge clock);
        #1;
        aw_ready = 1'b0;
        for (int i = 0; i < beats_per_line; i++) begin
            idle_cycles();
            w_ready = 1'b1;
            @(negedge clock);
            mem[{addr[8:6], 3'(i)}] = w_out.data;
            @(posedge clock);
            #1;
            w_ready = 1'b0;
        end
        idle_cycles();
        b_in = '{valid: 1'b1, resp: 2'b00};
        @(posedge clock);
        #1;
        b_in = '0;
    endtask

    initial begin
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        r_in     = '0;
        b_in     = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = {32'd0, base_addr | 32'(i << 3)} ^ pattern_key;
        end
        forever begin
            @(negedge clock);
            if (!reset && ar.valid)
                serve_read(ar.addr);
            else if (!reset && aw.valid)
                serve_write(aw.addr);
        end
    end

endmodule

// ==== verif/tb_dcache.sv ====
`timescale 1ns/10ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int num_requests = 200;
    localparam int watchdog_ns  = num_requests * 60 * 100 + 16 * 100;
    localparam logic [31:0] base_addr   = 32'h0004_0000; // Tag 0x800 and the three above it
    localparam logic [63:0] pattern_key = 64'h5a3c_96e1_0f87_d2b4;

    logic      clock = 1'b0;
    logic      reset;
    cpu_req_t  req;
    cpu_resp_t resp;
    axi_addr_t ar;
    axi_addr_t aw;
    axi_r_t    r_in;
    axi_w_t    w_out;
    axi_b_t    b_in;
    logic      ar_ready;
    logic      aw_ready;
    logic      w_ready;
    logic      r_ready;
    logic      b_ready;

    // Shadow of the CPU view of memory and of the tag state
    logic [63:0]          shadow_mem [64];
    logic [tag_width-1:0] shadow_tag [sets][ways];
    logic                 shadow_valid [sets][ways];
    logic                 shadow_dirty [sets][ways];
    logic                 shadow_rr;

    logic        exp_hit = 1'b0;
    logic        exp_evict = 1'b0;
    logic [31:0] exp_line_addr = '0;
    logic [31:0] exp_victim_addr = '0;
    logic [63:0] exp_rdata = '0;
    logic [63:0] exp_w_data;
    logic        new_req = 1'b0;
    logic        new_req_d1 = 1'b0;
    logic        new_req_d2 = 1'b0;
    logic        after_reset = 1'b0;
    logic        b_seen = 1'b0;
    logic [3:0]  w_count = '0;
    logic        ar_stall = 1'b0;
    logic        aw_stall = 1'b0;
    logic        w_stall = 1'b0;
    axi_addr_t   ar_q;
    axi_addr_t   aw_q;
    axi_w_t      w_q;
    int          errors = 0;

    dcache_top i_dut (
        .clock, .reset, .req, .resp, .ar, .ar_ready, .r_in, .r_ready,
        .aw, .aw_ready, .w_out, .w_ready, .b_in, .b_ready
    );

    axi_mem_model i_mem (
        .clock, .reset, .ar, .ar_ready, .r_in, .aw, .aw_ready, .w_out, .w_ready, .b_in
    );

    always #50 clock = ~clock;

    assign exp_w_data = shadow_mem[{exp_victim_addr[8:6], w_count[2:0]}];

    always @(posedge clock) begin
        after_reset <= reset;
        new_req_d1  <= new_req;
        new_req_d2  <= new_req_d1;
        ar_stall    <= ar.valid && !ar_ready;
        aw_stall    <= aw.valid && !aw_ready;
        w_stall     <= w_out.valid && !w_ready;
        ar_q        <= ar;
        aw_q        <= aw;
        w_q         <= w_out;
        if (reset || (aw.valid && aw_ready))
            w_count <= '0;
        else if (w_out.valid && w_ready)
            w_count <= w_count + 1'b1;
        if (reset || new_req)
            b_seen <= 1'b0;
        else if (b_in.valid && b_ready)
            b_seen <= 1'b1; // Write-back finished for this request
    end

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        errors++;
    endtask

    // Mask of the low bytes that the access size covers
    function automatic logic [63:0] size_mask(input access_size_e size);
        logic [63:0] mask;
        int          n;
        case (size)
            size_byte: n = 1;
            size_half: n = 2;
            size_word: n = 4;
            default:   n = 8;
        endcase
        mask = '0;
        for (int b = 0; b < 8; b++) begin
            if (b < n) mask[8*b +: 8] = 8'hff;
        end
        return mask;
    endfunction

    function automatic access_size_e pick_size();
        case ($urandom % 4)
            0:       return size_byte;
            1:       return size_half;
            2:       return size_word;
            default: return size_dword;
        endcase
    endfunction

    task automatic run_request(input logic write, input logic [31:0] addr,
                               input access_size_e size, input logic [63:0] wdata);
        logic                 set;
        logic [tag_width-1:0] tag;
        logic                 way;
        set = addr[offset_width];
        tag = addr[31:7];
        @(posedge clock);
        #1;
        exp_hit = 1'b0;
        way     = 1'b0;
        for (int w = 0; w < ways; w++) begin
            if (shadow_valid[set][w] && shadow_tag[set][w] == tag) begin
                exp_hit = 1'b1;
                way     = 1'(w);
            end
        end
        if (!exp_hit)
            way = !shadow_valid[set][0] ? 1'b0 : (!shadow_valid[set][1] ? 1'b1 : shadow_rr);
        exp_evict       = !exp_hit && shadow_valid[set][way] && shadow_dirty[set][way];
        exp_victim_addr = {shadow_tag[set][way], set, 6'd0};
        exp_line_addr   = {addr[31:6], 6'd0};
        exp_rdata       = shadow_mem[addr[8:3]] & size_mask(size);
        req = '{read: !write, write: write, addr: addr, size: size, wdata: wdata};
        new_req = 1'b1;
        @(posedge clock);
        #1;
        new_req = 1'b0;
        do @(negedge clock); while (!resp.done);
        if (!exp_hit) begin
            shadow_tag[set][way]   = tag;
            shadow_valid[set][way] = 1'b1;
            shadow_dirty[set][way] = 1'b0;
            shadow_rr              = !shadow_rr; // Pointer moves on every refill
        end
        if (write) begin
            shadow_dirty[set][way] = 1'b1;
            shadow_mem[addr[8:3]]  = (shadow_mem[addr[8:3]] & ~size_mask(size)) |
                                     (wdata & size_mask(size));
        end
    endtask

    assert property (@(posedge clock) after_reset |->
        {resp.done, ar.valid, aw.valid, w_out.valid, r_ready, b_ready} == 6'b0)
        else report_mismatch("done/valid/ready after reset", 0,
            $sampled({resp.done, ar.valid, aw.valid, w_out.valid, r_ready, b_ready}));
    assert property (@(posedge clock) disable iff (reset)
        (resp.done && req.read) |-> resp.rdata == exp_rdata)
        else report_mismatch("resp.rdata", exp_rdata, $sampled(resp.rdata));
    assert property (@(posedge clock) disable iff (reset) new_req_d1 |-> !resp.done)
        else report_mismatch("resp.done one edge after request", 0, 1);
    assert property (@(posedge clock) disable iff (reset) (new_req_d2 && exp_hit) |-> resp.done)
        else report_mismatch("resp.done two edges after hit", 1, 0);
    assert property (@(posedge clock) disable iff (reset) ar.valid |-> !exp_hit)
        else report_mismatch("ar.valid for a cached line", 0, 1);
    assert property (@(posedge clock) disable iff (reset) ar.valid |->
        {ar.addr, ar.len, ar.size, ar.burst} == {exp_line_addr, 8'd7, 3'd3, 2'd1})
        else report_mismatch("ar payload", {exp_line_addr, 8'd7, 3'd3, 2'd1},
            $sampled({ar.addr, ar.len, ar.size, ar.burst}));
    assert property (@(posedge clock) disable iff (reset) r_in.valid |-> r_ready)
        else report_mismatch("r_ready during read beat", 1, 0);
    assert property (@(posedge clock) disable iff (reset) aw.valid |-> exp_evict)
        else report_mismatch("aw.valid without dirty victim", 0, 1);
    assert property (@(posedge clock) disable iff (reset) aw.valid |->
        {aw.addr, aw.len, aw.size, aw.burst} == {exp_victim_addr, 8'd7, 3'd3, 2'd1})
        else report_mismatch("aw payload", {exp_victim_addr, 8'd7, 3'd3, 2'd1},
            $sampled({aw.addr, aw.len, aw.size, aw.burst}));
    assert property (@(posedge clock) disable iff (reset)
        (w_out.valid && w_ready) |-> w_out.data == exp_w_data)
        else report_mismatch("w_out.data", $sampled(exp_w_data), $sampled(w_out.data));
    assert property (@(posedge clock) disable iff (reset) w_out.valid |->
        {w_out.strb, w_out.last} == {8'hff, w_count == 4'd7})
        else report_mismatch("w_out.strb/last", {8'hff, $sampled(w_count) == 4'd7},
            $sampled({w_out.strb, w_out.last}));
    assert property (@(posedge clock) disable iff (reset) b_in.valid |-> b_ready)
        else report_mismatch("b_ready during write response", 1, 0);
    assert property (@(posedge clock) disable iff (reset)
        (ar.valid && exp_evict) |-> (b_seen && w_count == 4'd8))
        else report_mismatch("write-back done before ar", {1'b1, 4'd8},
            $sampled({b_seen, w_count}));
    assert property (@(posedge clock) disable iff (reset) ar_stall |-> ar == ar_q)
        else report_mismatch("ar while stalled", $sampled(ar_q), $sampled(ar));
    assert property (@(posedge clock) disable iff (reset) aw_stall |-> aw == aw_q)
        else report_mismatch("aw while stalled", $sampled(aw_q), $sampled(aw));
    assert property (@(posedge clock) disable iff (reset) w_stall |-> w_out == w_q)
        else report_mismatch("w_out while stalled", $sampled(w_q), $sampled(w_out));

    initial begin
        #(watchdog_ns);
        $display("Watchdog timeout: the requests did not complete in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0]  addr;
        logic         write;
        access_size_e size;
        void'($urandom(32'hf4e93d26));
        reset = 1'b1;
        req   = '0;
        addr  = base_addr;
        write = 1'b0;
        shadow_rr = 1'b0;
        for (int i = 0; i < 64; i++) begin
            shadow_mem[i] = {32'd0, base_addr | 32'(i << 3)} ^ pattern_key;
        end
        for (int s = 0; s < sets; s++) begin
            for (int w = 0; w < ways; w++) begin
                shadow_tag[s][w]   = '0;
                shadow_valid[s][w] = 1'b0;
                shadow_dirty[s][w] = 1'b0;
            end
        end
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int n = 0; n < num_requests; n++) begin
            if (!write)
                addr = base_addr | ($urandom % 512); // A write is read back at once
            write = write ? 1'b0 : 1'($urandom % 2);
            size  = pick_size();
            run_request(write, addr, size, {$urandom, $urandom});
        end
        @(posedge clock);
        #1;
        req = '0;
        repeat (2) @(posedge clock);
        $display("Requests: %0d, errors: %0d", num_requests, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
src/dcache_pkg.sv
src/beat_counter.sv
src/tag_store.sv
src/line_store.sv
src/dcache_fsm.sv
src/dcache_top.sv
verif/axi_mem_model.sv
verif/tb_dcache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_dcache \
    -f compile.f -Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1
